// File: logic/rs_pkg.sv
`default_nettype none

package rs_pkg;

	//////////////////////////////
	// Widths
	localparam int XLEN  = 32;                 // Data path width
	localparam int TAG_W = 4;                  // Physical tag width, 16 tags

	//////////////////////////////
	// Encodings
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,                     // a + b
		OP_SUB = 3'd1,                     // a - b
		OP_AND = 3'd2,                     // Bitwise and
		OP_OR  = 3'd3,                     // Bitwise or
		OP_XOR = 3'd4,                     // Bitwise xor
		OP_MUL = 3'd5                      // Low half of a * b
	} op_e;

	typedef enum logic {
		FU_ALU  = 1'b0,                    // Single-cycle ALU
		FU_MULT = 1'b1                     // Pipelined multiplier
	} fu_class_e;

	//////////////////////////////
	// Bundles
	typedef struct packed {
		logic            rdy;              // Value present
		logic [XLEN-1:0] val;              // Value, or tag in low bits while waiting
	} operand_t;

	typedef struct packed {
		op_e              op;              // Operation from rename
		logic [TAG_W-1:0] dest;            // Destination tag
		operand_t         opa;             // Source a
		operand_t         opb;             // Source b
	} dispatch_t;

	typedef struct packed {
		op_e              op;
		fu_class_e        fu_class;        // Unit that executes it
		logic [TAG_W-1:0] dest;
		operand_t         opa;
		operand_t         opb;
	} entry_t;

	typedef struct packed {
		op_e              op;
		logic [TAG_W-1:0] dest;
		logic [XLEN-1:0]  a;               // Resolved source a
		logic [XLEN-1:0]  b;               // Resolved source b
	} issue_t;

	typedef struct packed {
		logic             valid;           // Broadcast this cycle
		logic [TAG_W-1:0] tag;             // Producer tag
		logic [XLEN-1:0]  value;           // Result value
	} cdb_t;

endpackage

`default_nettype wire

// File: logic/op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module op_decode (
	input  wire                clock,
	input  wire                arst_n,
	input  wire                disp_req,       // Request from rename
	input  rs_pkg::dispatch_t  disp,           // Held stable while req is high
	input  wire                rs_full,        // Station back-pressure
	output logic               disp_ack,       // Handshake acknowledge
	output logic               load,           // One-cycle load strobe to station
	output rs_pkg::entry_t     load_entry      // Entry loaded on the strobe edge
);

	import rs_pkg::*;

	//////////////////////////////
	// Handshake
	// A new request is one not yet acknowledged, so each req loads once
	assign load = disp_req & ~disp_ack & ~rs_full;  // Withheld while the station is full

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			disp_ack <= 1'b0;
		end else if (load) begin
			disp_ack <= 1'b1;              // Entry goes in on this same edge
		end else if (!disp_req) begin
			disp_ack <= 1'b0;              // Release after req sampled low
		end
	end

	//////////////////////////////
	// Classify
	always_comb begin
		load_entry.op       = disp.op;
		load_entry.dest     = disp.dest;
		load_entry.opa      = disp.opa;
		load_entry.opb      = disp.opb;
		load_entry.fu_class = (disp.op == OP_MUL) ? FU_MULT : FU_ALU;  // Only mul leaves the ALU
	end

endmodule

`default_nettype wire

// File: logic/rs_entry.sv
`timescale 1ns/1ps
`default_nettype none

module rs_entry (
	input  wire             clock,
	input  wire             arst_n,
	input  wire             load,              // Fill this slot
	input  rs_pkg::entry_t  load_entry,        // Instruction to fill with
	input  rs_pkg::cdb_t    cdb,               // Result broadcast
	input  wire             issue_take,        // Slot picked for issue
	output logic            busy,              // Slot holds an instruction
	output logic            ready,             // Both operands present
	output rs_pkg::entry_t  held               // Stored instruction
);

	import rs_pkg::*;

	entry_t cur;                               // Load path or stored copy
	entry_t nxt;                               // After CDB wake-up

	// Swap a waiting operand for the broadcast value on a tag match
	function automatic operand_t snoop(input operand_t opnd, input cdb_t bus);
		operand_t res;
		res = opnd;
		if (!opnd.rdy && bus.valid && (bus.tag == opnd.val[TAG_W-1:0])) begin
			res.rdy = 1'b1;
			res.val = bus.value;
		end
		return res;
	endfunction

	//////////////////////////////
	// Wake-up
	always_comb begin
		cur     = load ? load_entry : held;    // Snoop also applies at the load edge
		nxt     = cur;
		nxt.opa = snoop(cur.opa, cdb);
		nxt.opb = snoop(cur.opb, cdb);
	end

	always_ff @(posedge clock) begin
		if (load || busy) begin
			held <= nxt;
		end
	end

	//////////////////////////////
	// Occupancy
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
		end else if (load) begin
			busy <= 1'b1;
		end else if (issue_take) begin
			busy <= 1'b0;                  // Freed as it leaves for its unit
		end
	end

	assign ready = busy & held.opa.rdy & held.opb.rdy;  // Registered state only, so no same-edge issue

endmodule

`default_nettype wire

// File: logic/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
	parameter int RS_SIZE = 8                  // Number of slots
) (
	input  wire             clock,
	input  wire             arst_n,
	input  wire             load,              // Load strobe from decode
	input  rs_pkg::entry_t  load_entry,
	input  rs_pkg::cdb_t    cdb,               // Wake-up broadcast
	input  wire             alu_busy,          // ALU result not yet drained
	output rs_pkg::issue_t  alu_issue,
	output logic            alu_issue_valid,
	output rs_pkg::issue_t  mult_issue,
	output logic            mult_issue_valid,
	output logic            rs_full            // No free slot
);

	import rs_pkg::*;

	logic [RS_SIZE-1:0] busy_vec;              // Per-slot occupancy
	logic [RS_SIZE-1:0] ready_vec;             // Per-slot ready
	logic [RS_SIZE-1:0] free_vec;              // Candidates for a load
	logic [RS_SIZE-1:0] alu_req;               // Ready ALU work
	logic [RS_SIZE-1:0] mult_req;              // Ready multiplier work
	logic [RS_SIZE-1:0] load_vec;              // One-hot load target
	logic [RS_SIZE-1:0] alu_take;              // One-hot ALU pick
	logic [RS_SIZE-1:0] mult_take;             // One-hot multiplier pick
	logic [RS_SIZE-1:0] take_vec;              // Slots leaving this edge
	entry_t             held_arr [RS_SIZE];    // Slot contents

	// Isolate the lowest set bit
	function automatic logic [RS_SIZE-1:0] first_one(input logic [RS_SIZE-1:0] req);
		return req & (~req + 1'b1);
	endfunction

	function automatic issue_t to_issue(input entry_t e);
		issue_t u;
		u.op   = e.op;
		u.dest = e.dest;
		u.a    = e.opa.val;
		u.b    = e.opb.val;
		return u;
	endfunction

	//////////////////////////////
	// Slots
	for (genvar i = 0; i < RS_SIZE; i++) begin : g_slot
		rs_entry u_entry (
			.clock      (clock),
			.arst_n     (arst_n),
			.load       (load_vec[i]),
			.load_entry (load_entry),
			.cdb        (cdb),
			.issue_take (take_vec[i]),
			.busy       (busy_vec[i]),
			.ready      (ready_vec[i]),
			.held       (held_arr[i])
		);
	end

	//////////////////////////////
	// Allocation and selection
	always_comb begin
		for (int i = 0; i < RS_SIZE; i++) begin
			free_vec[i] = ~busy_vec[i];
			alu_req[i]  = ready_vec[i] & (held_arr[i].fu_class == FU_ALU);
			mult_req[i] = ready_vec[i] & (held_arr[i].fu_class == FU_MULT);
		end
	end

	assign load_vec  = load ? first_one(free_vec) : '0;   // Lowest free slot
	assign alu_take  = alu_busy ? '0 : first_one(alu_req); // Hold ALU work under back-pressure
	assign mult_take = first_one(mult_req);                // Multiplier always accepts
	assign take_vec  = alu_take | mult_take;               // Classes never overlap

	assign rs_full = &busy_vec;

	//////////////////////////////
	// Issue muxes
	always_comb begin
		alu_issue  = '0;
		mult_issue = '0;
		for (int i = 0; i < RS_SIZE; i++) begin
			if (alu_take[i]) begin
				alu_issue = to_issue(held_arr[i]);
			end
			if (mult_take[i]) begin
				mult_issue = to_issue(held_arr[i]);
			end
		end
	end

	assign alu_issue_valid  = |alu_take;
	assign mult_issue_valid = |mult_take;

endmodule

`default_nettype wire

// File: logic/fu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module fu_alu (
	input  wire             clock,
	input  wire             arst_n,
	input  rs_pkg::issue_t  issue,             // Operation from station
	input  wire             issue_valid,
	input  wire             grant,             // CDB taken this cycle
	output logic            busy,              // Result stuck without grant
	output rs_pkg::cdb_t    res                // Offered result
);

	import rs_pkg::*;

	logic             res_valid;               // Holding register full
	logic [TAG_W-1:0] res_tag;
	logic [XLEN-1:0]  res_value;
	logic [XLEN-1:0]  alu_out;

	always_comb begin
		case (issue.op)
			OP_ADD:  alu_out = issue.a + issue.b;
			OP_SUB:  alu_out = issue.a - issue.b;
			OP_AND:  alu_out = issue.a & issue.b;
			OP_OR:   alu_out = issue.a | issue.b;
			OP_XOR:  alu_out = issue.a ^ issue.b;
			default: alu_out = '0;         // Mul never routed here
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else if (issue_valid) begin
			res_valid <= 1'b1;             // Refill, possibly as the old one drains
		end else if (grant) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_valid) begin
			res_tag   <= issue.dest;
			res_value <= alu_out;
		end
	end

	assign busy = res_valid & ~grant;          // Free when empty or draining now
	assign res  = '{valid: res_valid, tag: res_tag, value: res_value};

endmodule

`default_nettype wire

// File: logic/fu_mult.sv
`timescale 1ns/1ps
`default_nettype none

module fu_mult #(
	parameter int MULT_STAGES = 3              // Pipeline depth
) (
	input  wire             clock,
	input  wire             arst_n,
	input  rs_pkg::issue_t  issue,             // Operation from station
	input  wire             issue_valid,
	output rs_pkg::cdb_t    res                // Product at pipe exit
);

	import rs_pkg::*;

	logic [MULT_STAGES-1:0] vld_q;             // Per-stage valid
	logic [TAG_W-1:0]       tag_q  [MULT_STAGES];
	logic [XLEN-1:0]        prod_q [MULT_STAGES];
	logic [XLEN-1:0]        prod_in;           // Low half of full product

	assign prod_in = issue.a * issue.b;        // Truncates to XLEN

	//////////////////////////////
	// Valid pipe
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= issue_valid;
			for (int s = 1; s < MULT_STAGES; s++) begin
				vld_q[s] <= vld_q[s-1];
			end
		end
	end

	//////////////////////////////
	// Payload pipe
	// Shifts every cycle, one new product can enter each edge
	always_ff @(posedge clock) begin
		tag_q[0]  <= issue.dest;
		prod_q[0] <= prod_in;
		for (int s = 1; s < MULT_STAGES; s++) begin
			tag_q[s]  <= tag_q[s-1];
			prod_q[s] <= prod_q[s-1];
		end
	end

	assign res = '{
		valid: vld_q[MULT_STAGES-1],
		tag:   tag_q[MULT_STAGES-1],
		value: prod_q[MULT_STAGES-1]
	};

endmodule

`default_nettype wire

// File: logic/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
	input  wire           clock,
	input  wire           arst_n,
	input  rs_pkg::cdb_t  alu_res,             // Offered by ALU
	input  rs_pkg::cdb_t  mult_res,            // Offered by multiplier
	output logic          alu_grant,           // ALU result accepted this cycle
	output rs_pkg::cdb_t  cdb                  // Registered broadcast
);

	import rs_pkg::*;

	logic             cdb_valid;
	logic [TAG_W-1:0] cdb_tag;
	logic [XLEN-1:0]  cdb_value;

	// Multiplier cannot stall, so it always wins
	assign alu_grant = alu_res.valid & ~mult_res.valid;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= mult_res.valid | alu_res.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (mult_res.valid) begin
			cdb_tag   <= mult_res.tag;
			cdb_value <= mult_res.value;
		end else if (alu_grant) begin
			cdb_tag   <= alu_res.tag;
			cdb_value <= alu_res.value;
		end
	end

	assign cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};  // One edge after the offer

endmodule

`default_nettype wire

// File: logic/ooo_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_top #(
	parameter int RS_SIZE     = 8,             // Station slots
	parameter int MULT_STAGES = 3              // Multiplier depth
) (
	input  wire                clock,
	input  wire                arst_n,
	input  wire                disp_req,       // Rename request
	input  rs_pkg::dispatch_t  disp,
	output logic               disp_ack,
	output rs_pkg::cdb_t       cdb,            // Result broadcast, stands in for writeback
	output logic               rs_full
);

	import rs_pkg::*;

	logic   load;                              // Decode to station
	entry_t load_entry;
	issue_t alu_issue;
	logic   alu_issue_valid;
	issue_t mult_issue;
	logic   mult_issue_valid;
	logic   alu_busy;                          // ALU back-pressure
	logic   alu_grant;
	cdb_t   alu_res;
	cdb_t   mult_res;

	//////////////////////////////
	// Dispatch and station
	op_decode u_op_decode (
		.clock      (clock),
		.arst_n     (arst_n),
		.disp_req   (disp_req),
		.disp       (disp),
		.rs_full    (rs_full),
		.disp_ack   (disp_ack),
		.load       (load),
		.load_entry (load_entry)
	);

	reservation_station #(
		.RS_SIZE (RS_SIZE)
	) u_reservation_station (
		.clock            (clock),
		.arst_n           (arst_n),
		.load             (load),
		.load_entry       (load_entry),
		.cdb              (cdb),
		.alu_busy         (alu_busy),
		.alu_issue        (alu_issue),
		.alu_issue_valid  (alu_issue_valid),
		.mult_issue       (mult_issue),
		.mult_issue_valid (mult_issue_valid),
		.rs_full          (rs_full)
	);

	//////////////////////////////
	// Units and result bus
	fu_alu u_fu_alu (
		.clock       (clock),
		.arst_n      (arst_n),
		.issue       (alu_issue),
		.issue_valid (alu_issue_valid),
		.grant       (alu_grant),
		.busy        (alu_busy),
		.res         (alu_res)
	);

	fu_mult #(
		.MULT_STAGES (MULT_STAGES)
	) u_fu_mult (
		.clock       (clock),
		.arst_n      (arst_n),
		.issue       (mult_issue),
		.issue_valid (mult_issue_valid),
		.res         (mult_res)
	);

	cdb_arbiter u_cdb_arbiter (
		.clock     (clock),
		.arst_n    (arst_n),
		.alu_res   (alu_res),
		.mult_res  (mult_res),
		.alu_grant (alu_grant),
		.cdb       (cdb)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD = 50             // 100 ns period
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

endmodule

`default_nettype wire

// File: verif/ooo_issue_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_sva (
	input wire           clock,
	input wire           arst_n,
	input wire           disp_req,
	input wire           disp_ack,
	input rs_pkg::cdb_t  cdb
);

	// Ack only answers a live request
	ack_needs_req: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(disp_ack) |-> $past(disp_req))
		else $error("disp_ack rose without a request");

	// Release one edge after req is seen low
	ack_release: assert property (@(posedge clock) disable iff (!arst_n)
		(disp_ack && !disp_req) |=> !disp_ack)
		else $error("disp_ack held after req dropped");

	cdb_tag_known: assert property (@(posedge clock) disable iff (!arst_n)
		cdb.valid |-> !$isunknown(cdb.tag))
		else $error("cdb tag unknown while valid");

endmodule

bind ooo_issue_top ooo_issue_sva u_ooo_issue_sva (
	.clock    (clock),
	.arst_n   (arst_n),
	.disp_req (disp_req),
	.disp_ack (disp_ack),
	.cdb      (cdb)
);

`default_nettype wire

// File: verif/tb_ooo_issue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_issue;

	import rs_pkg::*;

	localparam int NTAGS   = 1 << TAG_W;       // Physical tag count
	localparam int TIMEOUT = 500;              // Cycles per wait

	logic      clock;
	logic      arst_n;
	logic      disp_req;
	dispatch_t disp;
	logic      disp_ack;
	cdb_t      cdb;
	logic      rs_full;

	int              seed = 64770;
	int              errors;
	int              checks;
	int              tests_run;
	int              tests_failed;
	int              test_err0;                // Errors at test start
	string           cur_name;
	int              tag_state [NTAGS];        // 0 unused, 1 in flight, 2 broadcast
	logic [XLEN-1:0] exp_val [NTAGS];          // Expected result per tag
	bit              is_mul [NTAGS];
	int              inflight_cnt;
	bit              mul_prev;                 // Last cycle carried a product
	bit              mul_overlap_seen;         // Products on two cycles in a row
	int              last_ack_wait;            // Cycles ack was withheld
	bit              full_block_seen;          // Req stalled by rs_full

	tb_clock_gen u_clock_gen (.clock(clock));

	ooo_issue_top #(
		.RS_SIZE     (8),
		.MULT_STAGES (3)
	) u_ooo_issue_top (
		.clock    (clock),
		.arst_n   (arst_n),
		.disp_req (disp_req),
		.disp     (disp),
		.disp_ack (disp_ack),
		.cdb      (cdb),
		.rs_full  (rs_full)
	);

	//////////////////////////////
	// Reference model
	function automatic logic [XLEN-1:0] ref_result(input op_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_MUL:  return a * b;             // Low XLEN bits only
			default: return '0;
		endcase
	endfunction

	function automatic int rnd(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Value if already broadcast or on the bus now, else the tag
	function automatic operand_t resolve(input int src, input logic [XLEN-1:0] v);
		operand_t r;
		if (src < 0) begin
			r.rdy = 1'b1;
			r.val = v;
		end else if (tag_state[src] == 2 || (cdb.valid && cdb.tag == src[TAG_W-1:0])) begin
			r.rdy = 1'b1;
			r.val = exp_val[src];
		end else begin
			r.rdy = 1'b0;
			r.val = XLEN'(src);            // Tag in low bits
		end
		return r;
	endfunction

	function automatic int pick_src();
		int t;
		if (rnd(2) == 0) begin
			return -1;                     // Plain value
		end
		t = rnd(NTAGS);
		return (tag_state[t] == 0) ? -1 : t;
	endfunction

	//////////////////////////////
	// Rename and dispatch
	task automatic pick_dest(input int sa, input int sb, output int dest);
		int start;
		int tries;
		int t;
		dest  = -1;
		tries = 0;
		while (dest < 0 && tries < TIMEOUT) begin
			start = rnd(NTAGS);
			for (int k = 0; k < NTAGS; k++) begin
				t = (start + k) % NTAGS;
				if (dest < 0 && tag_state[t] != 1 && t != sa && t != sb) begin
					dest = t;
				end
			end
			if (dest < 0) begin
				@(negedge clock);      // All tags busy
				tries++;
			end
		end
		if (dest < 0) begin
			errors++;
			$display("Timed out waiting for a free tag");
		end
	endtask

	task automatic send(input op_e op, input int sa, input logic [XLEN-1:0] va, input int sb,
			input logic [XLEN-1:0] vb, output int dest);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		operand_t        opa;
		operand_t        opb;
		int              waited;
		pick_dest(sa, sb, dest);
		if (dest < 0) begin
			return;
		end
		a      = (sa < 0) ? va : exp_val[sa];
		b      = (sb < 0) ? vb : exp_val[sb];
		opa    = resolve(sa, va);
		opb    = resolve(sb, vb);
		waited = 0;
		// A tag operand must load before its producer broadcasts
		while ((!opa.rdy || !opb.rdy) && rs_full && waited < TIMEOUT) begin
			@(negedge clock);
			waited++;
			opa = resolve(sa, va);
			opb = resolve(sb, vb);
		end
		if (waited >= TIMEOUT) begin
			errors++;
			$display("Timed out waiting for a free station slot");
			dest = -1;
			return;
		end
		tag_state[dest] = 1;
		exp_val[dest]   = ref_result(op, a, b);
		is_mul[dest]    = (op == OP_MUL);
		inflight_cnt++;
		disp.op   = op;
		disp.dest = dest[TAG_W-1:0];
		disp.opa  = opa;
		disp.opb  = opb;
		disp_req  = 1'b1;
		@(negedge clock);
		waited = 1;
		while (!disp_ack && waited < TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		last_ack_wait = waited - 1;            // Extra cycles beyond the minimum
		disp_req      = 1'b0;
		if (!disp_ack) begin
			errors++;
			$display("No ack for the request with tag %0d", dest);
			return;
		end
		waited = 0;
		@(negedge clock);
		while (disp_ack && waited < TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (disp_ack) begin
			errors++;
			$display("Ack did not drop after the request was released");
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (inflight_cnt != 0 && waited < TIMEOUT * 4) begin
			@(negedge clock);
			waited++;
		end
		if (inflight_cnt != 0) begin
			errors++;
			$display("Timed out with %0d results never broadcast", inflight_cnt);
		end
	endtask

	task automatic start_test(input string name);
		cur_name  = name;
		test_err0 = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors > test_err0) tests_failed++;
		$display("Test %0d %s: %s", tests_run, cur_name, (errors > test_err0) ? "failed" : "ok");
	endtask

	//////////////////////////////
	// Result checker
	always @(posedge clock) begin : result_check
		bit mul_now;
		mul_now = 1'b0;
		if (arst_n && cdb.valid) begin
			checks++;
			assert (tag_state[cdb.tag] == 1) else begin
				errors++;
				$display("Broadcast of tag %0d which is not in flight", cdb.tag);
			end
			if (tag_state[cdb.tag] == 1) begin
				assert (cdb.value == exp_val[cdb.tag]) else begin
					errors++;
					$display("[ERROR] cdb.value tag %h: got %h, expected %h",
						cdb.tag, cdb.value, exp_val[cdb.tag]);
				end
				mul_now            = is_mul[cdb.tag];
				tag_state[cdb.tag] = 2;    // Free for reuse, value known
				inflight_cnt--;
			end
		end
		if (mul_now && mul_prev) mul_overlap_seen = 1'b1;
		mul_prev = mul_now;
		if (disp_req && !disp_ack && rs_full) full_block_seen = 1'b1;
	end

	//////////////////////////////
	// Stimulus
	initial begin
		int p1;
		int p2;
		int c1;
		int c2;
		int c3;
		int c4;
		int t;
		int d;
		int sa;
		int sb;
		arst_n   = 1'b0;
		disp_req = 1'b0;
		disp     = '0;
		for (int i = 0; i < NTAGS; i++) begin
			tag_state[i] = 0;
			exp_val[i]   = '0;
			is_mul[i]    = 1'b0;
		end
		repeat (16) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);

		start_test("reset state");
		assert (disp_ack === 1'b0) else begin
			errors++;
			$display("[ERROR] disp_ack: got %h, expected 0", disp_ack);
		end
		assert (cdb.valid === 1'b0) else begin
			errors++;
			$display("[ERROR] cdb.valid: got %h, expected 0", cdb.valid);
		end
		assert (rs_full === 1'b0) else begin
			errors++;
			$display("[ERROR] rs_full: got %h, expected 0", rs_full);
		end
		end_test();

		start_test("independent alu ops");
		for (int i = 0; i < 10; i++) begin
			send(op_e'(i % 5), -1, $random(seed), -1, $random(seed), d);
		end
		drain();
		end_test();

		start_test("multiplies in flight");
		mul_overlap_seen = 1'b0;
		send(OP_MUL, -1, $random(seed), -1, $random(seed), p1);
		// Muls parked on one product wake together and enter the pipe on successive edges
		for (int i = 0; i < 8; i++) begin
			if (i % 3 == 2) begin
				send(OP_ADD, -1, $random(seed), -1, $random(seed), d);
			end else begin
				send(OP_MUL, p1, '0, -1, $random(seed), d);
			end
			assert (last_ack_wait == 0) else begin
				errors++;
				$display("Request with tag %0d waited %0d cycles for ack", d, last_ack_wait);
			end
		end
		drain();
		assert (mul_overlap_seen) else begin
			errors++;
			$display("Multiply products never broadcast on consecutive cycles");
		end
		end_test();

		start_test("dependency chains");
		send(OP_ADD, -1, $random(seed), -1, $random(seed), p1);
		send(OP_MUL, -1, $random(seed), -1, $random(seed), p2);
		send(OP_SUB, p1, '0, p2, '0, c1);      // Waits on both producers
		send(OP_XOR, c1, '0, p1, '0, c2);
		send(OP_MUL, c2, '0, c1, '0, c3);
		send(OP_OR, c3, '0, p2, '0, c4);
		send(OP_AND, c4, '0, -1, $random(seed), d);
		drain();
		end_test();

		start_test("station full");
		full_block_seen = 1'b0;
		send(OP_MUL, -1, $random(seed), -1, $random(seed) | 1, t);
		// Serial multiply chain piles up waiting entries
		for (int i = 0; i < 24 && !rs_full; i++) begin
			send(OP_MUL, t, '0, -1, $random(seed) | 1, t);
		end
		assert (rs_full) else begin
			errors++;
			$display("Station never became full");
		end
		send(OP_XOR, -1, $random(seed), -1, $random(seed), d);
		assert (last_ack_wait > 0 && full_block_seen) else begin
			errors++;
			$display("Ack was not withheld while the station was full");
		end
		drain();
		assert (rs_full === 1'b0) else begin
			errors++;
			$display("[ERROR] rs_full: got %h, expected 0", rs_full);
		end
		send(OP_ADD, -1, $random(seed), -1, $random(seed), d);
		drain();
		end_test();

		start_test("random mix");
		for (int i = 0; i < 200; i++) begin
			sa = pick_src();
			sb = pick_src();
			send(op_e'(rnd(6)), sa, $random(seed), sb, $random(seed), d);
		end
		drain();
		end_test();

		$display("Tests %0d, failed %0d, broadcasts checked %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
logic/rs_pkg.sv
logic/op_decode.sv
logic/rs_entry.sv
logic/reservation_station.sv
logic/fu_alu.sv
logic/fu_mult.sv
logic/cdb_arbiter.sv
logic/ooo_issue_top.sv
verif/tb_clock_gen.sv
verif/ooo_issue_sva.sv
verif/tb_ooo_issue.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_issue -f all.f \
	-o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 ; \
	grep -q "^Result: PASSED$" sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }
